/* box_overlay.f */
common/video_pkg.sv
common/box_pkg.sv
video_timing/video_timing.sv
src/box_regs.sv
draw_window/draw_window.sv
src/box_overlay_top.sv
tests/tb_box_overlay.sv

/* common/box_pkg.sv */
`default_nettype none

package box_pkg;

    import video_pkg::*;

    localparam int N_BOX     = 4;
    localparam int BOX_IDX_W = $clog2(N_BOX);
    localparam int BORDER    = 1;  // Outline thickness in pixels.

    ////////////////////
    // Register map
    ////////////////////

    localparam int REGS_PER_BOX = 3;
    localparam int N_REGS       = N_BOX * REGS_PER_BOX;
    localparam int ADR_W        = 4;

    // Word address is box index times REGS_PER_BOX plus one of these.
    localparam int REG_START = 0;
    localparam int REG_END   = 1;
    localparam int REG_STYLE = 2;

    // Corner word, x in bits 26 to 16 and y in bits 9 to 0.
    typedef struct packed {
        logic [31-(16+X_W):0] rsvd_hi;
        logic [X_W-1:0]       x;
        logic [15-Y_W:0]      rsvd_lo;
        logic [Y_W-1:0]       y;
    } coord_word_t;

    // Style word, enable in bit 24 and the colour below it.
    typedef struct packed {
        logic [6:0]         rsvd;
        logic               en;
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
    } style_word_t;

    typedef union packed {
        coord_word_t coord;
        style_word_t style;
    } box_word_t;

endpackage : box_pkg

`default_nettype wire

/* common/video_pkg.sv */
`default_nettype none

package video_pkg;

    ////////////////////
    // Frame geometry
    ////////////////////

    localparam int H_ACT   = 64;
    localparam int V_ACT   = 32;
    localparam int H_TOTAL = 80;  // Active pixels plus horizontal blanking.
    localparam int V_TOTAL = 36;

    // Both sync pulses are active high. The end positions are exclusive.
    localparam int H_SYNC_START = 68;
    localparam int H_SYNC_END   = 72;
    localparam int V_SYNC_START = 33;
    localparam int V_SYNC_END   = 34;

    ////////////////////
    // Widths
    ////////////////////

    localparam int X_W = 11;  // Leaves room for frames up to 2048 pixels wide.
    localparam int Y_W = 10;

    localparam int COLOR_W = 8;
    localparam int RGB_W   = 3 * COLOR_W;

    localparam logic [COLOR_W-1:0] BG_BLUE = 8'h40;

endpackage : video_pkg

`default_nettype wire

/* draw_window/draw_window.sv */
`timescale 1ns/10ps
`default_nettype none

module draw_window
    import video_pkg::*;
    import box_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_hsync,
    input  logic                   in_vsync,
    input  logic                   in_de,
    input  logic [X_W-1:0]         in_x,
    input  logic [Y_W-1:0]         in_y,
    input  logic [COLOR_W-1:0]     in_r,
    input  logic [COLOR_W-1:0]     in_g,
    input  logic [COLOR_W-1:0]     in_b,
    input  logic [N_BOX-1:0]       box_en,
    input  logic [N_BOX*X_W-1:0]   box_sx,
    input  logic [N_BOX*Y_W-1:0]   box_sy,
    input  logic [N_BOX*X_W-1:0]   box_ex,
    input  logic [N_BOX*Y_W-1:0]   box_ey,
    input  logic [N_BOX*RGB_W-1:0] box_color,
    output logic                   out_hsync,
    output logic                   out_vsync,
    output logic                   out_de,
    output logic [X_W-1:0]         out_x,
    output logic [Y_W-1:0]         out_y,
    output logic [COLOR_W-1:0]     out_r,
    output logic [COLOR_W-1:0]     out_g,
    output logic [COLOR_W-1:0]     out_b
);

    logic [N_BOX-1:0] hit;
    logic [RGB_W-1:0] color [N_BOX];
    logic [RGB_W-1:0] pix;

    ////////////////////
    // Outline hit test
    ////////////////////

    for (genvar i = 0; i < N_BOX; i++) begin : g_box
        logic [X_W-1:0] sx;
        logic [X_W-1:0] ex;
        logic [Y_W-1:0] sy;
        logic [Y_W-1:0] ey;
        logic           outer;
        logic           inner_x;
        logic           inner_y;

        assign sx       = box_sx[i*X_W +: X_W];
        assign ex       = box_ex[i*X_W +: X_W];
        assign sy       = box_sy[i*Y_W +: Y_W];
        assign ey       = box_ey[i*Y_W +: Y_W];
        assign color[i] = box_color[i*RGB_W +: RGB_W];

        assign outer = in_x >= sx && in_x <= ex && in_y >= sy && in_y <= ey;

        // The inner rectangle is empty when the box is thinner than two borders.
        assign inner_x = {1'b0, in_x} >= {1'b0, sx} + (X_W+1)'(BORDER) &&
                         {1'b0, in_x} + (X_W+1)'(BORDER) <= {1'b0, ex};
        assign inner_y = {1'b0, in_y} >= {1'b0, sy} + (Y_W+1)'(BORDER) &&
                         {1'b0, in_y} + (Y_W+1)'(BORDER) <= {1'b0, ey};

        assign hit[i] = box_en[i] && in_de && outer && !(inner_x && inner_y);
    end

    // Later boxes overwrite earlier ones, so the highest index wins.
    always_comb begin
        pix = {in_r, in_g, in_b};
        for (int i = 0; i < N_BOX; i++) begin
            if (hit[i]) begin
                pix = color[i];
            end
        end
    end

    ////////////////////
    // Output stage
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            out_hsync <= 1'b0;
            out_vsync <= 1'b0;
            out_de    <= 1'b0;
            out_x     <= '0;
            out_y     <= '0;
            out_r     <= '0;
            out_g     <= '0;
            out_b     <= '0;
        end else begin
            out_hsync               <= in_hsync;
            out_vsync               <= in_vsync;
            out_de                  <= in_de;
            out_x                   <= in_x;
            out_y                   <= in_y;
            {out_r, out_g, out_b}   <= pix;
        end
    end

    a_de_latency : assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst) |-> out_de == $past(in_de)
    ) else $error("out_de does not follow in_de by one cycle");

endmodule : draw_window

`default_nettype wire

/* src/box_overlay_top.sv */
`timescale 1ns/10ps
`default_nettype none

module box_overlay_top
    import video_pkg::*;
    import box_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [ADR_W-1:0]   wb_adr,
    input  logic [31:0]        wb_dat_w,
    output logic [31:0]        wb_dat_r,
    output logic               wb_ack,
    output logic               out_hsync,
    output logic               out_vsync,
    output logic               out_de,
    output logic [X_W-1:0]     out_x,
    output logic [Y_W-1:0]     out_y,
    output logic [COLOR_W-1:0] out_r,
    output logic [COLOR_W-1:0] out_g,
    output logic [COLOR_W-1:0] out_b
);

    // Raster stream from the timing block.
    logic               vt_hsync;
    logic               vt_vsync;
    logic               vt_de;
    logic               frame_start;
    logic [X_W-1:0]     vt_x;
    logic [Y_W-1:0]     vt_y;
    logic [COLOR_W-1:0] bg_r;
    logic [COLOR_W-1:0] bg_g;
    logic [COLOR_W-1:0] bg_b;

    // Shadow box settings.
    logic [N_BOX-1:0]       box_en;
    logic [N_BOX*X_W-1:0]   box_sx;
    logic [N_BOX*Y_W-1:0]   box_sy;
    logic [N_BOX*X_W-1:0]   box_ex;
    logic [N_BOX*Y_W-1:0]   box_ey;
    logic [N_BOX*RGB_W-1:0] box_color;

    video_timing u_video_timing (
        .clk         (clk),
        .rst         (rst),
        .hsync       (vt_hsync),
        .vsync       (vt_vsync),
        .de          (vt_de),
        .frame_start (frame_start),
        .x           (vt_x),
        .y           (vt_y),
        .bg_r        (bg_r),
        .bg_g        (bg_g),
        .bg_b        (bg_b)
    );

    box_regs u_box_regs (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .frame_start (frame_start),
        .box_en      (box_en),
        .box_sx      (box_sx),
        .box_sy      (box_sy),
        .box_ex      (box_ex),
        .box_ey      (box_ey),
        .box_color   (box_color)
    );

    draw_window u_draw_window (
        .clk       (clk),
        .rst       (rst),
        .in_hsync  (vt_hsync),
        .in_vsync  (vt_vsync),
        .in_de     (vt_de),
        .in_x      (vt_x),
        .in_y      (vt_y),
        .in_r      (bg_r),
        .in_g      (bg_g),
        .in_b      (bg_b),
        .box_en    (box_en),
        .box_sx    (box_sx),
        .box_sy    (box_sy),
        .box_ex    (box_ex),
        .box_ey    (box_ey),
        .box_color (box_color),
        .out_hsync (out_hsync),
        .out_vsync (out_vsync),
        .out_de    (out_de),
        .out_x     (out_x),
        .out_y     (out_y),
        .out_r     (out_r),
        .out_g     (out_g),
        .out_b     (out_b)
    );

endmodule : box_overlay_top

`default_nettype wire

/* src/box_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module box_regs
    import video_pkg::*;
    import box_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [ADR_W-1:0]       wb_adr,
    input  logic [31:0]            wb_dat_w,
    output logic [31:0]            wb_dat_r,
    output logic                   wb_ack,
    input  logic                   frame_start,
    output logic [N_BOX-1:0]       box_en,
    output logic [N_BOX*X_W-1:0]   box_sx,
    output logic [N_BOX*Y_W-1:0]   box_sy,
    output logic [N_BOX*X_W-1:0]   box_ex,
    output logic [N_BOX*Y_W-1:0]   box_ey,
    output logic [N_BOX*RGB_W-1:0] box_color
);

    logic                 adr_ok;
    logic [BOX_IDX_W-1:0] adr_box;
    logic [1:0]           adr_field;
    logic                 wr_en;
    box_word_t            wr_word;
    box_word_t            rd_word;

    // Working set, written from the bus.
    logic [N_BOX-1:0] w_en;
    logic [X_W-1:0]   w_sx    [N_BOX];
    logic [Y_W-1:0]   w_sy    [N_BOX];
    logic [X_W-1:0]   w_ex    [N_BOX];
    logic [Y_W-1:0]   w_ey    [N_BOX];
    logic [RGB_W-1:0] w_color [N_BOX];

    ////////////////////
    // Bus decode
    ////////////////////

    assign adr_ok    = wb_adr < ADR_W'(N_REGS);
    assign adr_box   = BOX_IDX_W'(wb_adr / ADR_W'(REGS_PER_BOX));
    assign adr_field = 2'(wb_adr % ADR_W'(REGS_PER_BOX));
    assign wr_word   = wb_dat_w;
    assign wr_en     = wb_ack && wb_cyc && wb_stb && wb_we && adr_ok;  // Commits on the ack cycle.

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_cyc && wb_stb && !wb_ack;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            w_en <= '0;
        end else if (wr_en && adr_field == 2'(REG_STYLE)) begin
            w_en[adr_box] <= wr_word.style.en;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (adr_field)
                2'(REG_START): begin
                    w_sx[adr_box] <= wr_word.coord.x;
                    w_sy[adr_box] <= wr_word.coord.y;
                end
                2'(REG_END): begin
                    w_ex[adr_box] <= wr_word.coord.x;
                    w_ey[adr_box] <= wr_word.coord.y;
                end
                default: begin
                    w_color[adr_box] <= {wr_word.style.r, wr_word.style.g, wr_word.style.b};
                end
            endcase
        end
    end

    // Unused bits and unmapped addresses read as zero.
    always_comb begin
        rd_word = '0;
        if (adr_ok) begin
            case (adr_field)
                2'(REG_START): begin
                    rd_word.coord.x = w_sx[adr_box];
                    rd_word.coord.y = w_sy[adr_box];
                end
                2'(REG_END): begin
                    rd_word.coord.x = w_ex[adr_box];
                    rd_word.coord.y = w_ey[adr_box];
                end
                default: begin
                    rd_word.style.en = w_en[adr_box];
                    {rd_word.style.r, rd_word.style.g, rd_word.style.b} = w_color[adr_box];
                end
            endcase
        end
    end

    assign wb_dat_r = rd_word;

    ////////////////////
    // Frame shadow
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            box_en <= '0;
        end else if (frame_start) begin
            box_en <= w_en;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_start) begin
            for (int i = 0; i < N_BOX; i++) begin
                box_sx[i*X_W +: X_W]          <= w_sx[i];
                box_sy[i*Y_W +: Y_W]          <= w_sy[i];
                box_ex[i*X_W +: X_W]          <= w_ex[i];
                box_ey[i*Y_W +: Y_W]          <= w_ey[i];
                box_color[i*RGB_W +: RGB_W]   <= w_color[i];
            end
        end
    end

    a_ack_in_cycle : assert property (
        @(posedge clk) disable iff (rst)
        wb_ack |-> wb_cyc && wb_stb
    ) else $error("ack raised without an active bus cycle");

    a_ack_single : assert property (
        @(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack
    ) else $error("ack held for two cycles");

endmodule : box_regs

`default_nettype wire

/* tests/tb_box_overlay.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_box_overlay
    import video_pkg::*;
    import box_pkg::*;
();

    localparam int FRAME_CYCLES    = H_TOTAL * V_TOTAL;
    localparam int TEST_FRAMES     = 6;
    localparam int WATCHDOG_CYCLES = (TEST_FRAMES + 1) * FRAME_CYCLES;  // One frame of margin.

    logic               clk;
    logic               rst;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [ADR_W-1:0]   wb_adr;
    logic [31:0]        wb_dat_w;
    logic [31:0]        wb_dat_r;
    logic               wb_ack;
    logic               out_hsync;
    logic               out_vsync;
    logic               out_de;
    logic [X_W-1:0]     out_x;
    logic [Y_W-1:0]     out_y;
    logic [COLOR_W-1:0] out_r;
    logic [COLOR_W-1:0] out_g;
    logic [COLOR_W-1:0] out_b;

    int seed;
    int errors;
    int reads;

    // Register model. The shadow set lags the DUT shadow by one cycle, like the pixels.
    logic [N_REGS-1:0][31:0] work;
    logic [N_REGS-1:0][31:0] work_d;
    logic [N_REGS-1:0][31:0] shadow;

    logic [31:0] data [N_REGS];
    logic [31:0] rd;
    int          sx0;
    int          sy0;
    int          ex0;
    int          ey0;

    box_overlay_top i_box_overlay_top (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .out_hsync (out_hsync),
        .out_vsync (out_vsync),
        .out_de    (out_de),
        .out_x     (out_x),
        .out_y     (out_y),
        .out_r     (out_r),
        .out_g     (out_g),
        .out_b     (out_b)
    );

    always #5 clk = ~clk;

    ////////////////////
    // Reference model
    ////////////////////

    // Keeps only the fields that the register file stores at this address.
    function automatic logic [31:0] masked_word(input int adr, input logic [31:0] word);
        box_word_t in_word;
        box_word_t out_word;
        in_word  = word;
        out_word = '0;
        if (adr >= N_REGS) begin
            return '0;
        end
        if (adr % REGS_PER_BOX == REG_STYLE) begin
            out_word.style.en = in_word.style.en;
            out_word.style.r  = in_word.style.r;
            out_word.style.g  = in_word.style.g;
            out_word.style.b  = in_word.style.b;
        end else begin
            out_word.coord.x = in_word.coord.x;
            out_word.coord.y = in_word.coord.y;
        end
        return out_word;
    endfunction

    function automatic logic [RGB_W-1:0] expected_pixel(
        input logic [X_W-1:0]          px,
        input logic [Y_W-1:0]          py,
        input logic                    pde,
        input logic [N_REGS-1:0][31:0] regs
    );
        box_word_t        s;
        box_word_t        e;
        box_word_t        st;
        logic [RGB_W-1:0] rgb;
        logic             outer;
        logic             inner;
        int               x;
        int               y;
        int               sx;
        int               sy;
        int               ex;
        int               ey;
        if (!pde) begin
            return '0;
        end
        x   = px;
        y   = py;
        rgb = {8'(x * 4), 8'(y * 8), BG_BLUE};
        for (int b = 0; b < N_BOX; b++) begin
            s     = regs[b*REGS_PER_BOX + REG_START];
            e     = regs[b*REGS_PER_BOX + REG_END];
            st    = regs[b*REGS_PER_BOX + REG_STYLE];
            sx    = s.coord.x;
            sy    = s.coord.y;
            ex    = e.coord.x;
            ey    = e.coord.y;
            outer = x >= sx && x <= ex && y >= sy && y <= ey;
            inner = x >= sx + BORDER && x <= ex - BORDER && y >= sy + BORDER && y <= ey - BORDER;
            if (st.style.en && outer && !inner) begin
                rgb = {st.style.r, st.style.g, st.style.b};  // Later boxes win.
            end
        end
        return rgb;
    endfunction

    // One pixel per clock, wrapping at the end of the line and of the frame.
    function automatic logic [X_W+Y_W-1:0] next_position(input logic [X_W-1:0] px,
                                                         input logic [Y_W-1:0] py);
        int nx;
        int ny;
        nx = px + 1;
        ny = py;
        if (nx == H_TOTAL) begin
            nx = 0;
            ny = (py + 1) % V_TOTAL;
        end
        return {X_W'(nx), Y_W'(ny)};
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            work_d <= '0;
            shadow <= '0;
        end else begin
            work_d <= work;
            if (out_x == '0 && out_y == '0) begin
                shadow <= work_d;
            end
        end
    end

    ////////////////////
    // Output checks
    ////////////////////

    a_pixel : assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst) |-> {out_r, out_g, out_b} == expected_pixel(out_x, out_y, out_de, shadow)
    ) else begin
        errors++;
        $display("ERR %0t: pixel (%0d,%0d) is %06h, expected %06h", $time,
                 $sampled(out_x), $sampled(out_y), $sampled({out_r, out_g, out_b}),
                 expected_pixel($sampled(out_x), $sampled(out_y), $sampled(out_de),
                                $sampled(shadow)));
    end

    a_position : assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst) |=> {out_x, out_y} == next_position($past(out_x), $past(out_y))
    ) else begin
        errors++;
        $display("ERR %0t: position (%0d,%0d) does not follow the raster", $time,
                 $sampled(out_x), $sampled(out_y));
    end

    a_de : assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst) |-> out_de == (out_x < H_ACT && out_y < V_ACT)
    ) else begin
        errors++;
        $display("ERR %0t: de wrong at (%0d,%0d)", $time, $sampled(out_x), $sampled(out_y));
    end

    a_hsync : assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst) |-> out_hsync == (out_x >= H_SYNC_START && out_x < H_SYNC_END)
    ) else begin
        errors++;
        $display("ERR %0t: hsync wrong at x %0d", $time, $sampled(out_x));
    end

    a_vsync : assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst) |-> out_vsync == (out_y >= V_SYNC_START && out_y < V_SYNC_END)
    ) else begin
        errors++;
        $display("ERR %0t: vsync wrong at y %0d", $time, $sampled(out_y));
    end

    // Every access starts with a fresh strobe and is acked on the following cycle.
    a_ack_timing : assert property (
        @(posedge clk) disable iff (rst)
        $rose(wb_stb) |=> wb_ack
    ) else begin
        errors++;
        $display("ERR %0t: ack missing one cycle after the strobe", $time);
    end

    ////////////////////
    // Bus and stimulus
    ////////////////////

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    task automatic write_reg(input logic [ADR_W-1:0] adr, input logic [31:0] word);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= word;
        @(posedge clk);
        while (!wb_ack) @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        if (adr < N_REGS) begin
            work[adr] <= masked_word(adr, word);  // The DUT commits on this same edge.
        end
    endtask

    task automatic read_reg(input logic [ADR_W-1:0] adr, output logic [31:0] word);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        @(posedge clk);
        while (!wb_ack) @(posedge clk);
        word = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic check_read(input int adr, input logic [31:0] got, input logic [31:0] exp);
        reads++;
        assert (got == exp) else begin
            errors++;
            $display("ERR %0t: address %0d read %08h, expected %08h", $time, adr, got, exp);
        end
    endtask

    task automatic place_box(input int b, input int sx, input int sy, input int ex,
                             input int ey, input logic [RGB_W-1:0] color);
        box_word_t w;
        w         = '0;
        w.coord.x = X_W'(sx);
        w.coord.y = Y_W'(sy);
        write_reg(ADR_W'(b * REGS_PER_BOX + REG_START), w);
        w.coord.x = X_W'(ex);
        w.coord.y = Y_W'(ey);
        write_reg(ADR_W'(b * REGS_PER_BOX + REG_END), w);
        w          = '0;
        w.style.en = 1'b1;
        {w.style.r, w.style.g, w.style.b} = color;
        write_reg(ADR_W'(b * REGS_PER_BOX + REG_STYLE), w);
    endtask

    task automatic wait_frames(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk);
            if (out_de && out_x == '0 && out_y == '0) begin
                seen++;
            end
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        work     = '0;
        seed     = 99;
        errors   = 0;
        reads    = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // All boxes are off after reset, so the first frame is pure background.
        wait_frames(2);

        for (int a = 0; a < N_REGS; a++) begin
            data[a] = $random(seed);
            write_reg(ADR_W'(a), data[a]);
        end
        for (int a = 0; a < N_REGS; a++) begin
            read_reg(ADR_W'(a), rd);
            check_read(a, rd, masked_word(a, data[a]));
        end
        write_reg(ADR_W'(13), 32'hffff_ffff);
        read_reg(ADR_W'(13), rd);
        check_read(13, rd, 32'h0);

        // One box alone.
        for (int b = 1; b < N_BOX; b++) begin
            write_reg(ADR_W'(b * REGS_PER_BOX + REG_STYLE), 32'h0);
        end
        sx0 = rand_below(H_ACT - 2);
        sy0 = rand_below(V_ACT - 2);
        ex0 = sx0 + 2 + rand_below(H_ACT - sx0 - 2);
        ey0 = sy0 + 2 + rand_below(V_ACT - sy0 - 2);
        place_box(0, sx0, sy0, ex0, ey0, 24'(unsigned'($random(seed))));
        wait_frames(2);

        // Box 2 shares the top left corner of box 0 and must win there.
        place_box(2, sx0, sy0, sx0 + 2 + rand_below(H_ACT - sx0 - 2),
                  sy0 + 2 + rand_below(V_ACT - sy0 - 2), 24'(unsigned'($random(seed))));
        wait_frames(1);

        // Move box 0 halfway down the frame.
        @(posedge clk);
        while (out_y != Y_W'(V_ACT / 2)) @(posedge clk);
        sx0 = rand_below(H_ACT - 2);
        sy0 = rand_below(V_ACT - 2);
        ex0 = sx0 + 2 + rand_below(H_ACT - sx0 - 2);
        ey0 = sy0 + 2 + rand_below(V_ACT - sy0 - 2);
        place_box(0, sx0, sy0, ex0, ey0, 24'(unsigned'($random(seed))));
        wait_frames(2);

        $display("%0d register reads checked, %0d errors", reads, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired before the test sequence finished");
        $display("Simulation failed");
        $finish;
    end

endmodule : tb_box_overlay

`default_nettype wire

/* video_timing/video_timing.sv */
`timescale 1ns/10ps
`default_nettype none

module video_timing
    import video_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    output logic               hsync,
    output logic               vsync,
    output logic               de,
    output logic               frame_start,
    output logic [X_W-1:0]     x,
    output logic [Y_W-1:0]     y,
    output logic [COLOR_W-1:0] bg_r,
    output logic [COLOR_W-1:0] bg_g,
    output logic [COLOR_W-1:0] bg_b
);

    logic [X_W-1:0] h_cnt;
    logic [Y_W-1:0] v_cnt;
    logic           h_wrap;
    logic           v_wrap;
    logic [X_W+1:0] x_times4;
    logic [Y_W+2:0] y_times8;

    ////////////////////
    // Raster counters
    ////////////////////

    assign h_wrap = h_cnt == X_W'(H_TOTAL - 1);
    assign v_wrap = v_cnt == Y_W'(V_TOTAL - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_wrap) begin
                h_cnt <= '0;
                if (v_wrap) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    ////////////////////
    // Decoded outputs
    ////////////////////

    assign x = h_cnt;
    assign y = v_cnt;

    assign hsync       = h_cnt >= X_W'(H_SYNC_START) && h_cnt < X_W'(H_SYNC_END);
    assign vsync       = v_cnt >= Y_W'(V_SYNC_START) && v_cnt < Y_W'(V_SYNC_END);
    assign de          = h_cnt < X_W'(H_ACT) && v_cnt < Y_W'(V_ACT);
    assign frame_start = h_cnt == '0 && v_cnt == '0;

    // Gradient background, red follows x and green follows y.
    assign x_times4 = {h_cnt, 2'b00};
    assign y_times8 = {v_cnt, 3'b000};

    assign bg_r = de ? x_times4[COLOR_W-1:0] : '0;
    assign bg_g = de ? y_times8[COLOR_W-1:0] : '0;
    assign bg_b = de ? BG_BLUE : '0;

    a_de_in_line : assert property (
        @(posedge clk) disable iff (rst)
        de |-> x < X_W'(H_ACT)
    ) else $error("de is high past the active part of the line");

endmodule : video_timing

`default_nettype wire
